/* compile.f */
+incdir+common
common/gpioRegPkg.sv
common/timingPkg.sv
src/heartbeatGenerator.sv
markers/markerDivider.sv
src/statusReadback.sv
src/bpmTimingTop.sv
verification/bpmTiming_sva.sv
verification/bpmTimingTb.sv

/* Bender.yml */
package:
  name: bpm_timing

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/gpioRegPkg.sv
      - common/timingPkg.sv
      - src/heartbeatGenerator.sv
      - markers/markerDivider.sv
      - src/statusReadback.sv
      - src/bpmTimingTop.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/bpmTiming_sva.sv
      - verification/bpmTimingTb.sv

/* verification/bpmTimingTb.sv */
`timescale 1ns/1ps
`include "bpm_defs.svh"

module bpmTimingTb import gpioRegPkg::*, timingPkg::*; ();

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 8;
    localparam int waitLimit    = 1000;
    localparam int randomRounds = 40;

    logic                     sysClk;
    logic                     rstN;
    regStrobesT               gpioStrobes;
    gpioWordT                 gpioOut;
    regIndexT                 readAddr;
    gpioWordT                 readData;
    logic                     heartbeat;
    logic [`MARKER_COUNT-1:0] markers;

    int     seed;
    int     errorCount;
    int     timeoutCount;
    int     checkCount;
    logic   rstLevel;
    longint cycleNo;

    ////////////////////
    // Reference model state
    // Left counters hold the cycles until the next pulse
    hbCountT     modelHbReload;
    int          modelHbLeft;
    markerCountT modelDivReload [`MARKER_COUNT];
    int          modelDivLeft [`MARKER_COUNT];
    logic        modelSynced [`MARKER_COUNT];
    markerCountT modelCount [`MARKER_COUNT];
    gpioWordT    modelReadData;

    bpmTimingTop dut_i (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .gpioStrobes(gpioStrobes),
        .gpioOut    (gpioOut),
        .readAddr   (readAddr),
        .readData   (readData),
        .heartbeat  (heartbeat),
        .markers    (markers)
    );

    initial begin
        sysClk = 1'b0;
        forever begin
            #(clkPeriod / 2) sysClk = ~sysClk;
        end
    end

    ////////////////////
    // Model
    function automatic logic modelHeartbeat();
        return (modelHbLeft == 0);
    endfunction

    // Heartbeat forces every marker
    function automatic logic modelMarker(int k);
        return modelHeartbeat() || (modelDivLeft[k] == 0);
    endfunction

    function automatic gpioWordT modelWord(regIndexT idx);
        gpioWordT word;
        word = '0;
        if (idx == `IDX_HB_RELOAD) begin
            word = gpioWordT'(modelHbReload);
        end
        for (int k = 0; k < `MARKER_COUNT; k++) begin
            if (idx == `IDX_FA_RELOAD + k) begin
                word = gpioWordT'(modelDivReload[k]);
                word[`GPIO_WIDTH-1] = modelSynced[k];
            end
            if (idx == `IDX_FA_COUNT + k) begin
                word = gpioWordT'(modelCount[k]);
            end
        end
        return word;
    endfunction

    // Advance one clock edge with the inputs the DUT sees at that edge
    function automatic void stepModel();
        logic                     hbNow;
        logic [`MARKER_COUNT-1:0] markNow;
        if (!rstN) begin
            modelHbReload = hbCountT'(`HB_RELOAD_RESET);
            modelHbLeft   = `HB_RELOAD_RESET + 2;
            modelReadData = '0;
            modelDivReload[0] = markerCountT'(`FA_RELOAD_RESET);
            modelDivReload[1] = markerCountT'(`SA_RELOAD_RESET);
            for (int k = 0; k < `MARKER_COUNT; k++) begin
                modelDivLeft[k] = int'(modelDivReload[k]);
                modelSynced[k]  = 1'b0;
                modelCount[k]   = '0;
            end
        end else begin
            hbNow = modelHeartbeat();
            for (int k = 0; k < `MARKER_COUNT; k++) begin
                markNow[k] = modelMarker(k);
            end
            modelReadData = modelWord(readAddr);
            for (int k = 0; k < `MARKER_COUNT; k++) begin
                if (markNow[k]) begin
                    modelCount[k] = modelCount[k] + 1'b1;
                end
                if (gpioStrobes[`IDX_FA_RELOAD + k]) begin
                    modelSynced[k] = 1'b0;
                end else if (hbNow) begin
                    // Aligned when the divider would have marked here anyway
                    modelSynced[k] = (modelDivLeft[k] == 0);
                end
                if (markNow[k]) begin
                    modelDivLeft[k] = int'(modelDivReload[k]);
                end else begin
                    modelDivLeft[k] = modelDivLeft[k] - 1;
                end
                if (gpioStrobes[`IDX_FA_RELOAD + k]) begin
                    modelDivReload[k] = gpioOut[`MARKER_WIDTH-1:0];
                end
            end
            if (hbNow) begin
                modelHbLeft = int'(modelHbReload) + 1;
            end else begin
                modelHbLeft = modelHbLeft - 1;
            end
            if (gpioStrobes[`IDX_HB_RELOAD]) begin
                modelHbReload = gpioOut[`HB_WIDTH-1:0];
            end
        end
    endfunction

    ////////////////////
    // Helpers
    function automatic int randRange(int lo, int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    function automatic regIndexT randomAddr();
        return regIndexT'($random(seed));
    endfunction

    task automatic checkValue(string testName, logic [63:0] expected, logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h (cycle %0d)",
                     testName, expected, actual, cycleNo);
        end
    endtask

    // One clock, then compare outputs away from the edge
    task automatic tick(regStrobesT stb, gpioWordT word, regIndexT addr);
        logic [`MARKER_COUNT-1:0] expMarkers;
        @(posedge sysClk);
        stepModel();
        rstN        <= rstLevel;
        gpioStrobes <= stb;
        gpioOut     <= word;
        readAddr    <= addr;
        @(negedge sysClk);
        cycleNo++;
        for (int k = 0; k < `MARKER_COUNT; k++) begin
            expMarkers[k] = modelMarker(k);
        end
        checkValue("heartbeat", modelHeartbeat(), heartbeat);
        checkValue("markers", expMarkers, markers);
        checkValue("readData", modelReadData, readData);
        if (heartbeat) begin
            checkValue("marker on heartbeat", {`MARKER_COUNT{1'b1}}, markers);
        end
    endtask

    // Noise on the write word, no strobe
    task automatic idle();
        tick('0, gpioWordT'($random(seed)), randomAddr());
    endtask

    task automatic writeReg(regIndexT idx, gpioWordT value);
        regStrobesT stb;
        stb      = '0;
        stb[idx] = 1'b1;
        tick(stb, value, randomAddr());
    endtask

    task automatic readReg(regIndexT idx, output gpioWordT actual, output gpioWordT expected);
        tick('0, gpioWordT'($random(seed)), idx);
        expected = modelWord(idx);
        idle();
        actual = readData;
    endtask

    task automatic readCheck(string testName, regIndexT idx, gpioWordT expected);
        gpioWordT actual;
        gpioWordT modelExp;
        readReg(idx, actual, modelExp);
        checkValue(testName, expected, actual);
    endtask

    task automatic waitHeartbeat(output int cycles);
        cycles = 0;
        do begin
            idle();
            cycles++;
        end while (!heartbeat && cycles < waitLimit);
        if (!heartbeat) begin
            timeoutCount++;
            $display("Error: timed out waiting for heartbeat after %0d cycles", cycles);
        end
    endtask

    // Spacing between markers that a heartbeat did not force
    task automatic markerSpacing(int k, int spacing, int window);
        longint lastMark;
        logic   haveMark;
        haveMark = 1'b0;
        lastMark = 0;
        for (int n = 0; n < window; n++) begin
            idle();
            if (markers[k]) begin
                if (haveMark && !heartbeat) begin
                    checkValue("marker spacing", spacing, cycleNo - lastMark);
                end
                haveMark = 1'b1;
                lastMark = cycleNo;
            end
        end
    endtask

    task automatic syncCheck(int k, logic aligned);
        int       d;
        int       r;
        int       lo;
        int       gap;
        gpioWordT expected;
        d = randRange(2, 40);
        if (aligned) begin
            lo = (22 + d) / (d + 1);
            r  = (d + 1) * randRange(lo, 202 / (d + 1)) - 2;
        end else begin
            r = randRange(20, 200);
            if ((r + 2) % (d + 1) == 0) begin
                r = (r > 20) ? r - 1 : r + 1;
            end
        end
        writeReg(`IDX_HB_RELOAD, gpioWordT'(r));
        writeReg(regIndexT'(`IDX_FA_RELOAD + k), gpioWordT'(d));
        expected = gpioWordT'(d);
        readCheck("status after write", regIndexT'(`IDX_FA_RELOAD + k), expected);
        // First pulse realigns, second one tells
        waitHeartbeat(gap);
        waitHeartbeat(gap);
        checkValue("heartbeat spacing", r + 2, gap);
        expected[`GPIO_WIDTH-1] = aligned;
        readCheck("synced after realign", regIndexT'(`IDX_FA_RELOAD + k), expected);
        waitHeartbeat(gap);
        readCheck("synced held", regIndexT'(`IDX_FA_RELOAD + k), expected);
    endtask

    ////////////////////
    // Test sequence
    initial begin
        int       gap;
        int       action;
        int       k;
        int       value;
        gpioWordT actual;
        gpioWordT modelExp;

        seed         = 32'h9072_bbdc;
        errorCount   = 0;
        timeoutCount = 0;
        checkCount   = 0;
        cycleNo      = 0;
        rstLevel     = 1'b0;
        rstN         = 1'b0;
        gpioStrobes  = '0;
        gpioOut      = '0;
        readAddr     = '0;

        repeat (resetCycles - 1) begin
            tick('0, '0, '0);
        end
        rstLevel = 1'b1;
        tick('0, '0, '0);
        cycleNo = 0;

        // Quiet state right after reset
        checkValue("reset heartbeat", 0, heartbeat);
        checkValue("reset markers", 0, markers);
        checkValue("reset readData", 0, readData);
        readCheck("reset FA count", `IDX_FA_COUNT, '0);
        readCheck("reset SA count", `IDX_SA_COUNT, '0);
        readCheck("reset FA status", `IDX_FA_RELOAD, gpioWordT'(`FA_RELOAD_RESET));
        readCheck("reset SA status", `IDX_SA_RELOAD, gpioWordT'(`SA_RELOAD_RESET));
        readCheck("reset HB reload", `IDX_HB_RELOAD, gpioWordT'(`HB_RELOAD_RESET));
        waitHeartbeat(gap);
        checkValue("first heartbeat", `HB_RELOAD_RESET + 2, cycleNo);

        // Unmapped indices
        for (int idx = `REG_COUNT; idx < 8; idx++) begin
            readCheck("unused index", regIndexT'(idx), '0);
        end

        // Heartbeat reload writes
        repeat (3) begin
            value = randRange(20, 200);
            writeReg(`IDX_HB_RELOAD, gpioWordT'(value));
            readCheck("HB reload readback", `IDX_HB_RELOAD, gpioWordT'(value));
            waitHeartbeat(gap);
            waitHeartbeat(gap);
            checkValue("heartbeat spacing", value + 2, gap);
            waitHeartbeat(gap);
            checkValue("heartbeat spacing", value + 2, gap);
        end

        // Divider pacing
        for (int m = 0; m < `MARKER_COUNT; m++) begin
            value = randRange(2, 40);
            writeReg(regIndexT'(`IDX_FA_RELOAD + m), gpioWordT'(value));
            readCheck("divider readback", regIndexT'(`IDX_FA_RELOAD + m), gpioWordT'(value));
            markerSpacing(m, value + 1, 400);
        end

        // Alignment status
        for (int m = 0; m < `MARKER_COUNT; m++) begin
            syncCheck(m, 1'b1);
            syncCheck(m, 1'b0);
            syncCheck(m, 1'b1);
        end

        ////////////////////
        // Random register traffic
        for (int round = 0; round < randomRounds; round++) begin
            action = randRange(0, 3);
            case (action)
                0: begin
                    writeReg(`IDX_HB_RELOAD, gpioWordT'(randRange(20, 200)));
                end
                1: begin
                    k = randRange(0, `MARKER_COUNT - 1);
                    writeReg(regIndexT'(`IDX_FA_RELOAD + k), gpioWordT'(randRange(2, 40)));
                end
                2: begin
                    // Count registers ignore writes
                    k = randRange(0, `MARKER_COUNT - 1);
                    writeReg(regIndexT'(`IDX_FA_COUNT + k), gpioWordT'($random(seed)));
                end
                default: begin
                    readReg(randomAddr(), actual, modelExp);
                    checkValue("random read", modelExp, actual);
                end
            endcase
            gap = randRange(0, 80);
            repeat (gap) begin
                idle();
            end
        end

        // Marker tallies against the model
        readReg(`IDX_FA_COUNT, actual, modelExp);
        checkValue("FA count", modelExp, actual);
        readReg(`IDX_SA_COUNT, actual, modelExp);
        checkValue("SA count", modelExp, actual);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verification/bpmTiming_sva.sv */
`timescale 1ns/1ps

module bpmTimingSva #(
    parameter bit dividerChecks = 1'b1
) (
    input logic sysClk,
    input logic rstN,
    input logic heartbeat,
    input logic reloadStrobe,
    input logic marker,
    input logic synced
);

    ////////////////////
    // Heartbeat is a single-cycle pulse
    heartbeatSingle: assert property (@(posedge sysClk) disable iff (!rstN)
        heartbeat |=> !heartbeat)
        else $error("heartbeat high in two consecutive cycles");

    // Divider always marks on a heartbeat
    markerOnHeartbeat: assert property (@(posedge sysClk) disable iff (!rstN)
        (dividerChecks && heartbeat) |-> marker)
        else $error("heartbeat without marker");

    // New divisor drops the alignment
    syncedClears: assert property (@(posedge sysClk) disable iff (!rstN)
        (dividerChecks && reloadStrobe) |=> !synced)
        else $error("synced still high after reload write");

endmodule

bind markerDivider bpmTimingSva #(.dividerChecks(1'b1)) dividerSva (
    .sysClk      (sysClk),
    .rstN        (rstN),
    .heartbeat   (heartbeat),
    .reloadStrobe(reloadStrobe),
    .marker      (marker),
    .synced      (synced)
);

bind heartbeatGenerator bpmTimingSva #(.dividerChecks(1'b0)) generatorSva (
    .sysClk      (sysClk),
    .rstN        (rstN),
    .heartbeat   (heartbeat),
    .reloadStrobe(reloadStrobe),
    .marker      (1'b0),
    .synced      (1'b0)
);

/* src/bpmTimingTop.sv */
`timescale 1ns/1ps
`include "bpm_defs.svh"

module bpmTimingTop import gpioRegPkg::*, timingPkg::*; (
    input  logic                     sysClk,
    input  logic                     rstN,
    input  regStrobesT               gpioStrobes,
    input  gpioWordT                 gpioOut,
    input  regIndexT                 readAddr,
    output gpioWordT                 readData,
    output logic                     heartbeat,
    output logic [`MARKER_COUNT-1:0] markers
);

    hbCountT                         hbReload;
    logic        [`MARKER_COUNT-1:0] synced;
    markerCountT [`MARKER_COUNT-1:0] markerReloads;

    ////////////////////
    // Local heartbeat source
    heartbeatGenerator heartbeatGen (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .reloadStrobe(gpioStrobes[`IDX_HB_RELOAD]),
        .gpioOut     (gpioOut),
        .heartbeat   (heartbeat),
        .reload      (hbReload)
    );

    ////////////////////
    // FA and SA marker dividers
    // Divider k takes reload index 1+k
    for (genvar k = 0; k < `MARKER_COUNT; k++) begin : genDivider
        markerDivider #(
            .resetReload((k == 0) ? markerCountT'(`FA_RELOAD_RESET)
                                  : markerCountT'(`SA_RELOAD_RESET))
        ) divider (
            .sysClk      (sysClk),
            .rstN        (rstN),
            .reloadStrobe(gpioStrobes[`IDX_FA_RELOAD + k]),
            .gpioOut     (gpioOut),
            .heartbeat   (heartbeat),
            .marker      (markers[k]),
            .synced      (synced[k]),
            .reload      (markerReloads[k])
        );
    end

    ////////////////////
    // Status and counts back onto the bus
    statusReadback readback (
        .sysClk       (sysClk),
        .rstN         (rstN),
        .readAddr     (readAddr),
        .hbReload     (hbReload),
        .markers      (markers),
        .synced       (synced),
        .markerReloads(markerReloads),
        .readData     (readData)
    );

endmodule

/* src/statusReadback.sv */
`timescale 1ns/1ps
`include "bpm_defs.svh"

module statusReadback import gpioRegPkg::*, timingPkg::*; (
    input  logic                            sysClk,
    input  logic                            rstN,
    input  regIndexT                        readAddr,
    input  hbCountT                         hbReload,
    input  logic        [`MARKER_COUNT-1:0] markers,
    input  logic        [`MARKER_COUNT-1:0] synced,
    input  markerCountT [`MARKER_COUNT-1:0] markerReloads,
    output gpioWordT                        readData
);

    localparam int countPad  = `GPIO_WIDTH - `MARKER_WIDTH;
    localparam int statusPad = `GPIO_WIDTH - 1 - `MARKER_WIDTH;
    localparam int hbPad     = `GPIO_WIDTH - `HB_WIDTH;

    markerCountT [`MARKER_COUNT-1:0] markerCounts;
    gpioWordT                        regWords [`REG_COUNT];

    ////////////////////
    // Marker tallies
    // Wrap at full width
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            markerCounts <= '0;
        end else begin
            for (int k = 0; k < `MARKER_COUNT; k++) begin
                if (markers[k]) begin
                    markerCounts[k] <= markerCounts[k] + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Register words
    assign regWords[`IDX_HB_RELOAD] = {{hbPad{1'b0}}, hbReload};

    for (genvar k = 0; k < `MARKER_COUNT; k++) begin : genWords
        // Synced flag on top, reload in the low bits
        assign regWords[`IDX_FA_RELOAD + k] = {synced[k], {statusPad{1'b0}}, markerReloads[k]};
        assign regWords[`IDX_FA_COUNT + k] = {{countPad{1'b0}}, markerCounts[k]};
    end

    ////////////////////
    // Read port
    // One cycle latency, unmapped indices read zero
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            readData <= '0;
        end else if (isRegIndex(readAddr)) begin
            readData <= regWords[readAddr];
        end else begin
            readData <= '0;
        end
    end

endmodule

/* markers/markerDivider.sv */
`timescale 1ns/1ps
`include "bpm_defs.svh"

module markerDivider import gpioRegPkg::*, timingPkg::*; #(
    parameter markerCountT resetReload = markerCountT'(`FA_RELOAD_RESET)
) (
    input  logic        sysClk,
    input  logic        rstN,
    input  logic        reloadStrobe,
    input  gpioWordT    gpioOut,
    input  logic        heartbeat,
    output logic        marker,
    output logic        synced,
    output markerCountT reload
);

    markerCountT divCounter;
    syncStateT   syncState;
    logic        counterZero;

    assign counterZero = (divCounter == '0);

    // Heartbeat always forces a marker, otherwise one per reload+1 cycles
    assign marker = heartbeat | counterZero;

    assign synced = (syncState == stateSynced);

    ////////////////////
    // Reload register
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            reload <= resetReload;
        end else if (reloadStrobe) begin
            reload <= gpioOut[`MARKER_WIDTH-1:0];
        end
    end

    ////////////////////
    // Divider counter
    // Free running between heartbeats, restarted by each marker
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            divCounter <= resetReload;
        end else if (marker) begin
            divCounter <= reload;
        end else begin
            divCounter <= divCounter - 1'b1;
        end
    end

    ////////////////////
    // Alignment FSM
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            syncState <= stateUnsynced;
        end else if (reloadStrobe) begin
            // New divisor, alignment unknown until the next heartbeats
            syncState <= stateUnsynced;
        end else if (heartbeat) begin
            // Aligned if the free-running count would have marked here anyway
            case (syncState)
                stateUnsynced: begin
                    if (counterZero) begin
                        syncState <= stateSynced;
                    end
                end
                stateSynced: begin
                    if (!counterZero) begin
                        syncState <= stateUnsynced;
                    end
                end
                default: begin
                    syncState <= stateUnsynced;
                end
            endcase
        end
    end

endmodule

/* src/heartbeatGenerator.sv */
`timescale 1ns/1ps
`include "bpm_defs.svh"

module heartbeatGenerator import gpioRegPkg::*, timingPkg::*; (
    input  logic     sysClk,
    input  logic     rstN,
    input  logic     reloadStrobe,
    input  gpioWordT gpioOut,
    output logic     heartbeat,
    output hbCountT  reload
);

    hbCounterT hbCounter;

    // Pulse while the counter has wrapped below zero
    assign heartbeat = hbCounter[`HB_WIDTH];

    ////////////////////
    // Reload register
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            reload <= hbCountT'(`HB_RELOAD_RESET);
        end else if (reloadStrobe) begin
            reload <= gpioOut[`HB_WIDTH-1:0];
        end
    end

    ////////////////////
    // Down-counter
    // Period is reload+2: reload down to zero, then one cycle wrapped
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            // One count high, as if a pulse had just reloaded it
            hbCounter <= hbCounterT'(`HB_RELOAD_RESET + 1);
        end else if (heartbeat) begin
            hbCounter <= {1'b0, reload};
        end else begin
            hbCounter <= hbCounter - 1'b1;
        end
    end

endmodule

/* common/timingPkg.sv */
`include "bpm_defs.svh"

package timingPkg;

    ////////////////////
    // Counter types

    // Heartbeat reload value
    typedef logic [`HB_WIDTH-1:0] hbCountT;

    // Heartbeat down-counter, top bit flags the pulse
    typedef logic [`HB_WIDTH:0] hbCounterT;

    // Divider reload and marker tally
    typedef logic [`MARKER_WIDTH-1:0] markerCountT;

    ////////////////////
    // Divider alignment state
    typedef enum logic {
        stateUnsynced,
        stateSynced
    } syncStateT;

endpackage

/* common/gpioRegPkg.sv */
`include "bpm_defs.svh"

package gpioRegPkg;

    ////////////////////
    // Register bus types

    // Shared write word and read word
    typedef logic [`GPIO_WIDTH-1:0] gpioWordT;

    // Register selector, wide enough for every index
    typedef logic [`REG_INDEX_WIDTH-1:0] regIndexT;

    // One single-cycle write strobe per register
    typedef logic [`REG_COUNT-1:0] regStrobesT;

    ////////////////////
    // Helpers

    // True for indices that map onto a register
    function automatic logic isRegIndex(regIndexT idx);
        return (idx < `REG_COUNT);
    endfunction

endpackage

/* common/bpm_defs.svh */
`ifndef BPM_DEFS_SVH
`define BPM_DEFS_SVH

////////////////////
// Widths
`define GPIO_WIDTH        32
`define REG_INDEX_WIDTH   3
`define HB_WIDTH          28
`define MARKER_WIDTH      16

// Index 0 is FA, index 1 is SA
`define MARKER_COUNT      2

////////////////////
// Register map
`define REG_COUNT         5
`define IDX_HB_RELOAD     0
`define IDX_FA_RELOAD     1
`define IDX_SA_RELOAD     2
`define IDX_FA_COUNT      3
`define IDX_SA_COUNT      4

// Reload values loaded by reset
`define HB_RELOAD_RESET   150
`define FA_RELOAD_RESET   9
`define SA_RELOAD_RESET   49

`endif
